/* hw/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	typedef logic [7:0] uart_byte_t;
	typedef logic [1:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;

	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		wb_addr_t adr;
		wb_data_t dat;
	} wb_req_t;

	typedef struct packed
	{
		logic ack;
		wb_data_t dat;
	} wb_rsp_t;

	localparam wb_addr_t ADDR_DATA = 2'd0;
	localparam wb_addr_t ADDR_STATUS = 2'd1;

	localparam int STATUS_RX_VALID = 0;
	localparam int STATUS_TX_BUSY = 1;
	localparam int STATUS_RX_OVERRUN = 2;
	localparam int STATUS_PARITY_ERROR = 3;

	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_t;
	typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_t;

	typedef struct packed
	{
		logic valid;
		logic parity_error;
		uart_byte_t data;
	} rx_event_t;

endpackage

`default_nettype wire

/* hw/uart_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_timer
	#(
		parameter int BAUD_RATE = 115_200,
		parameter int EXTERNAL_CLOCK = 50_000_000
	)
	(
		input wire clk,
		input wire async_nreset,

		input wire enable,
		input wire clear,

		output logic half_tick,
		output logic tick
	);

	localparam int PERIOD = EXTERNAL_CLOCK / BAUD_RATE;
	localparam int CNT_W = $clog2(PERIOD);

	typedef logic [CNT_W-1:0] count_t;

	localparam count_t LAST = count_t'(PERIOD - 1);
	localparam count_t HALF_POINT = count_t'(PERIOD / 2 - 1);

	count_t count_q;

	always_ff @(posedge clk, negedge async_nreset)
	begin
		if (!async_nreset)
			count_q <= '0;
		else if (clear)
			count_q <= '0;
		else if (enable)
			count_q <= (count_q == LAST) ? '0 : count_q + count_t'(1);
	end

	assign half_tick = enable && (count_q == HALF_POINT); // Middle of the bit period.
	assign tick = enable && (count_q == LAST); // Last cycle of the bit period.

	a_ticks_exclusive: assert property (@(posedge clk) disable iff (!async_nreset)
		!(half_tick && tick));

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx
	#(
		parameter int BAUD_RATE = 115_200,
		parameter int EXTERNAL_CLOCK = 50_000_000
	)
	(
		input wire clk,
		input wire async_nreset,

		input wire rxd,

		output uart_pkg::rx_event_t rx_event
	);

	import uart_pkg::*;

	rx_state_t state_q, state_next;
	logic [1:0] rxd_sync_q;
	logic rxd_s;
	uart_byte_t shift_q, shift_next;
	logic [2:0] bit_cnt_q, bit_cnt_next;
	rx_event_t event_q, event_next;

	logic timer_enable;
	logic timer_clear;
	logic timer_half_tick;
	logic timer_tick;

	uart_timer
	#(
		.BAUD_RATE(BAUD_RATE),
		.EXTERNAL_CLOCK(EXTERNAL_CLOCK)
	)
	u_timer
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.enable(timer_enable),
		.clear(timer_clear),
		.half_tick(timer_half_tick),
		.tick(timer_tick)
	);

	assign rxd_s = rxd_sync_q[1]; // The line is asynchronous to clk.

	always_comb
	begin
		state_next = state_q;
		shift_next = shift_q;
		bit_cnt_next = bit_cnt_q;
		event_next = '0;
		timer_enable = 1'b1;
		timer_clear = 1'b0;

		case (state_q)
			RX_IDLE:
			begin
				timer_enable = 1'b0;
				timer_clear = 1'b1; // Bit timing starts at the falling edge.
				if (!rxd_s)
					state_next = RX_START;
			end
			RX_START:
			begin
				if (timer_half_tick && rxd_s)
					state_next = RX_IDLE; // Glitch, not a start bit.
				else if (timer_tick)
				begin
					bit_cnt_next = '0;
					state_next = RX_DATA;
				end
			end
			RX_DATA:
			begin
				if (timer_half_tick)
					shift_next = {rxd_s, shift_q[7:1]}; // LSB arrives first.
				else if (timer_tick)
				begin
					if (bit_cnt_q == 3'd7)
						state_next = RX_PARITY;
					else
						bit_cnt_next = bit_cnt_q + 3'd1;
				end
			end
			RX_PARITY:
			begin
				if (timer_half_tick)
				begin
					event_next.data = shift_q;
					if (rxd_s == ^shift_q)
						event_next.valid = 1'b1;
					else
						event_next.parity_error = 1'b1;
				end
				if (timer_tick)
					state_next = RX_STOP;
			end
			RX_STOP:
			begin
				if (timer_tick)
					state_next = RX_IDLE;
			end
			default:
				state_next = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge async_nreset)
	begin
		if (!async_nreset)
		begin
			state_q <= RX_IDLE;
			rxd_sync_q <= 2'b11;
			bit_cnt_q <= '0;
			event_q <= '0;
		end
		else
		begin
			state_q <= state_next;
			rxd_sync_q <= {rxd_sync_q[0], rxd};
			bit_cnt_q <= bit_cnt_next;
			event_q <= event_next;
		end
	end

	always_ff @(posedge clk)
	begin
		shift_q <= shift_next;
	end

	assign rx_event = event_q;

	a_event_exclusive: assert property (@(posedge clk) disable iff (!async_nreset)
		!(event_q.valid && event_q.parity_error));

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_tx
	#(
		parameter int BAUD_RATE = 115_200,
		parameter int EXTERNAL_CLOCK = 50_000_000
	)
	(
		input wire clk,
		input wire async_nreset,

		input wire start,
		input wire uart_pkg::uart_byte_t data,

		output logic txd,
		output logic busy
	);

	import uart_pkg::*;

	tx_state_t state_q, state_next;
	uart_byte_t shift_q, shift_next;
	logic parity_q, parity_next;
	logic [2:0] bit_cnt_q, bit_cnt_next;
	logic txd_q, txd_next;

	logic timer_enable;
	logic timer_clear;
	logic timer_tick;

	uart_timer
	#(
		.BAUD_RATE(BAUD_RATE),
		.EXTERNAL_CLOCK(EXTERNAL_CLOCK)
	)
	u_timer
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.enable(timer_enable),
		.clear(timer_clear),
		.half_tick(),
		.tick(timer_tick)
	);

	always_comb
	begin
		state_next = state_q;
		shift_next = shift_q;
		parity_next = parity_q;
		bit_cnt_next = bit_cnt_q;
		timer_enable = 1'b1;
		timer_clear = 1'b0;

		case (state_q)
			TX_IDLE:
			begin
				timer_enable = 1'b0;
				timer_clear = 1'b1;
				if (start)
				begin
					shift_next = data;
					parity_next = ^data; // Even parity.
					state_next = TX_START;
				end
			end
			TX_START:
			begin
				if (timer_tick)
				begin
					bit_cnt_next = '0;
					state_next = TX_DATA;
				end
			end
			TX_DATA:
			begin
				if (timer_tick)
				begin
					shift_next = {1'b0, shift_q[7:1]};
					if (bit_cnt_q == 3'd7)
						state_next = TX_PARITY;
					else
						bit_cnt_next = bit_cnt_q + 3'd1;
				end
			end
			TX_PARITY:
			begin
				if (timer_tick)
					state_next = TX_STOP;
			end
			TX_STOP:
			begin
				if (timer_tick)
					state_next = TX_IDLE;
			end
			default:
				state_next = TX_IDLE;
		endcase

		case (state_next) // The line level follows the next state, so txd is a flop.
			TX_START: txd_next = 1'b0;
			TX_DATA: txd_next = shift_next[0];
			TX_PARITY: txd_next = parity_next;
			default: txd_next = 1'b1;
		endcase
	end

	always_ff @(posedge clk, negedge async_nreset)
	begin
		if (!async_nreset)
		begin
			state_q <= TX_IDLE;
			bit_cnt_q <= '0;
			txd_q <= 1'b1;
		end
		else
		begin
			state_q <= state_next;
			bit_cnt_q <= bit_cnt_next;
			txd_q <= txd_next;
		end
	end

	always_ff @(posedge clk)
	begin
		shift_q <= shift_next;
		parity_q <= parity_next;
	end

	assign txd = txd_q;
	assign busy = (state_q != TX_IDLE);

	a_no_start_busy: assert property (@(posedge clk) disable iff (!async_nreset)
		start |-> !busy);

endmodule

`default_nettype wire

/* hw/uart_wb_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_wb_regs
	(
		input wire clk,
		input wire async_nreset,

		input wire uart_pkg::wb_req_t wb_req,
		output uart_pkg::wb_rsp_t wb_rsp,

		input wire uart_pkg::rx_event_t rx_event,

		input wire tx_busy,
		output logic tx_start,
		output uart_pkg::uart_byte_t tx_data
	);

	import uart_pkg::*;

	logic ack_q;
	logic access;
	logic wr_data;
	logic wr_status;
	logic rd_data;
	logic tx_accept;

	logic rx_valid_q;
	logic rx_overrun_q;
	logic parity_error_q;
	logic tx_start_q;

	uart_byte_t rx_data_q;
	uart_byte_t tx_data_q;
	wb_data_t rd_data_q;
	wb_data_t rd_mux;
	wb_data_t status_word;

	assign access = wb_req.cyc && wb_req.stb && !ack_q; // New cycle, ack comes next.
	assign wr_data = access && wb_req.we && (wb_req.adr == ADDR_DATA);
	assign wr_status = access && wb_req.we && (wb_req.adr == ADDR_STATUS);
	assign rd_data = access && !wb_req.we && (wb_req.adr == ADDR_DATA);
	assign tx_accept = wr_data && !tx_busy; // Writes while busy are dropped.

	always_comb
	begin
		status_word = '0;
		status_word[STATUS_RX_VALID] = rx_valid_q;
		status_word[STATUS_TX_BUSY] = tx_busy;
		status_word[STATUS_RX_OVERRUN] = rx_overrun_q;
		status_word[STATUS_PARITY_ERROR] = parity_error_q;

		case (wb_req.adr)
			ADDR_DATA: rd_mux = wb_data_t'(rx_data_q);
			ADDR_STATUS: rd_mux = status_word;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk, negedge async_nreset)
	begin
		if (!async_nreset)
		begin
			ack_q <= 1'b0;
			tx_start_q <= 1'b0;
			rx_valid_q <= 1'b0;
			rx_overrun_q <= 1'b0;
			parity_error_q <= 1'b0;
		end
		else
		begin
			ack_q <= access;
			tx_start_q <= tx_accept; // Lands in the ack cycle.

			if (rx_event.valid)
				rx_valid_q <= 1'b1;
			else if (rd_data)
				rx_valid_q <= 1'b0;

			if (rx_event.valid && rx_valid_q && !rd_data)
				rx_overrun_q <= 1'b1; // Unread byte is being overwritten.
			else if (wr_status)
				rx_overrun_q <= 1'b0;

			if (rx_event.parity_error)
				parity_error_q <= 1'b1;
			else if (wr_status)
				parity_error_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_event.valid)
			rx_data_q <= rx_event.data;
		if (tx_accept)
			tx_data_q <= wb_req.dat[7:0];
		if (access)
			rd_data_q <= rd_mux;
	end

	assign wb_rsp = '{ack: ack_q, dat: rd_data_q};
	assign tx_start = tx_start_q;
	assign tx_data = tx_data_q;

	a_ack_single: assert property (@(posedge clk) disable iff (!async_nreset)
		ack_q |=> !ack_q);

endmodule

`default_nettype wire

/* hw/uart_top.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_top
	#(
		parameter int BAUD_RATE = 115_200,
		parameter int EXTERNAL_CLOCK = 50_000_000
	)
	(
		input wire clk,
		input wire async_nreset,

		input wire uart_pkg::wb_req_t wb_req,
		output uart_pkg::wb_rsp_t wb_rsp,

		input wire rxd,
		output logic txd
	);

	import uart_pkg::*;

	rx_event_t rx_event;
	logic tx_start;
	logic tx_busy;
	uart_byte_t tx_data;

	uart_wb_regs u_regs
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.rx_event(rx_event),
		.tx_busy(tx_busy),
		.tx_start(tx_start),
		.tx_data(tx_data)
	);

	uart_rx
	#(
		.BAUD_RATE(BAUD_RATE),
		.EXTERNAL_CLOCK(EXTERNAL_CLOCK)
	)
	u_rx
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.rxd(rxd),
		.rx_event(rx_event)
	);

	uart_tx
	#(
		.BAUD_RATE(BAUD_RATE),
		.EXTERNAL_CLOCK(EXTERNAL_CLOCK)
	)
	u_tx
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.start(tx_start),
		.data(tx_data),
		.txd(txd),
		.busy(tx_busy)
	);

endmodule

`default_nettype wire

/* tests/uart_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_checker
	#(
		parameter int BIT_CYCLES = 16
	)
	(
		input wire clk,
		input wire async_nreset,
		input wire txd,
		output int error_count
	);

	import uart_pkg::*;

	uart_byte_t frames[$];
	string test_name;
	int test_errors;
	int tests_run;
	int tests_failed;

	initial
	begin
		error_count = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] got);
		if (got !== expected)
		begin
			$display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, expected, got);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		error_count++;
		test_errors++;
	endtask

	task automatic expect_frame(input uart_byte_t b);
		frames.push_back(b);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (frames.size() != 0)
			report_problem("An expected frame never appeared on txd.");
		frames.delete();
		tests_run++;
		if (test_errors == 0)
		begin
			$display("PASS %s", test_name);
		end
		else
		begin
			tests_failed++;
			$display("FAIL %s (%0d errors)", test_name, test_errors);
		end
	endtask

	task automatic report_counts();
		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
	endtask

	task automatic decode_frame();
		logic [10:0] bits;
		uart_byte_t expected;
		repeat (BIT_CYCLES / 2) @(negedge clk); // Sample each bit near its middle.
		for (int i = 0; i < 11; i++)
		begin
			bits[i] = txd;
			if (i < 10)
				repeat (BIT_CYCLES) @(negedge clk);
		end
		if (frames.size() == 0)
		begin
			report_problem($sformatf("A frame with data 0x%02h appeared on txd unexpectedly.",
				bits[8:1]));
		end
		else
		begin
			expected = frames.pop_front();
			check_value("txd start bit", 32'h0, {31'h0, bits[0]});
			check_value("txd data", {24'h0, expected}, {24'h0, bits[8:1]});
			check_value("txd parity", {31'h0, ^expected}, {31'h0, bits[9]});
			check_value("txd stop bit", 32'h1, {31'h0, bits[10]});
		end
	endtask

	always @(negedge txd)
	begin
		if (async_nreset === 1'b1)
			decode_frame();
	end

endmodule

`default_nettype wire

/* tests/tb_uart_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_uart_top;

	import uart_pkg::*;

	localparam int BAUD_RATE = 625_000;
	localparam int EXTERNAL_CLOCK = 10_000_000;
	localparam int BIT_CYCLES = EXTERNAL_CLOCK / BAUD_RATE;
	localparam int MAX_STEPS = 32;

	logic clk;
	logic async_nreset;
	logic rxd;
	logic txd;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	int error_count;
	logic [23:0] steps [0:MAX_STEPS-1]; // Kind, byte, argument.

	uart_top
	#(
		.BAUD_RATE(BAUD_RATE),
		.EXTERNAL_CLOCK(EXTERNAL_CLOCK)
	)
	DUT
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.rxd(rxd),
		.txd(txd)
	);

	uart_checker
	#(
		.BIT_CYCLES(BIT_CYCLES)
	)
	u_checker
	(
		.clk(clk),
		.async_nreset(async_nreset),
		.txd(txd),
		.error_count(error_count)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#10; // Inputs change shortly after the rising edge.
	endtask

	task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: addr, dat: data};
		wait_cycles(1);
		while (!wb_rsp.ack)
			wait_cycles(1);
		wb_req = '0;
	endtask

	task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: addr, dat: '0};
		wait_cycles(1);
		while (!wb_rsp.ack)
			wait_cycles(1);
		data = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic checked_read(input wb_addr_t addr, input wb_data_t expected);
		wb_data_t data;
		wb_read(addr, data);
		u_checker.check_value((addr == ADDR_DATA) ? "DATA" : "STATUS", expected, data);
	endtask

	// Polls STATUS until some bit of mask is set, or until all of them are clear.
	task automatic wait_status(input wb_data_t mask, input logic set);
		wb_data_t status;
		wb_read(ADDR_STATUS, status);
		while (((status & mask) != '0) != set)
			wb_read(ADDR_STATUS, status);
	endtask

	task automatic send_frame(input uart_byte_t b, input logic parity_good);
		logic [10:0] frame;
		frame = {1'b1, (^b) ^ !parity_good, b, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			rxd = frame[i];
			wait_cycles(BIT_CYCLES);
		end
	endtask

	task automatic receive_byte(input uart_byte_t b, input logic parity_good);
		u_checker.begin_test($sformatf("receive 0x%02h parity %s", b,
			parity_good ? "good" : "bad"));
		send_frame(b, parity_good);
		wait_status(32'h9, 1'b1);
		if (parity_good)
		begin
			checked_read(ADDR_STATUS, 32'h1);
			checked_read(ADDR_DATA, {24'h0, b});
			checked_read(ADDR_STATUS, 32'h0);
		end
		else
		begin
			checked_read(ADDR_STATUS, 32'h8);
			wb_write(ADDR_STATUS, 32'h0);
			checked_read(ADDR_STATUS, 32'h0);
		end
		u_checker.finish_test();
	endtask

	task automatic transmit_byte(input uart_byte_t b, input int extra);
		u_checker.begin_test($sformatf("transmit 0x%02h with %0d writes while busy",
			b, extra));
		u_checker.expect_frame(b);
		wb_write(ADDR_DATA, {24'h0, b});
		for (int i = 0; i < extra; i++)
			wb_write(ADDR_DATA, {24'h0, ~b}); // Must be dropped.
		wait_status(32'h2, 1'b0);
		checked_read(ADDR_STATUS, 32'h0);
		u_checker.finish_test();
	endtask

	task automatic receive_overrun(input uart_byte_t first, input uart_byte_t second);
		u_checker.begin_test($sformatf("overrun 0x%02h then 0x%02h", first, second));
		send_frame(first, 1'b1);
		send_frame(second, 1'b1);
		wait_status(32'h1, 1'b1);
		checked_read(ADDR_STATUS, 32'h5);
		checked_read(ADDR_DATA, {24'h0, second});
		wb_write(ADDR_STATUS, 32'h0);
		checked_read(ADDR_STATUS, 32'h0);
		u_checker.finish_test();
	endtask

	initial
	begin
		logic [7:0] kind;
		uart_byte_t arg_a;
		uart_byte_t arg_b;
		async_nreset = 1'b0;
		rxd = 1'b1;
		wb_req = '0;
		for (int i = 0; i < MAX_STEPS; i++)
			steps[i] = '0;
		$readmemh("tests/uart_stim.txt", steps);
		wait_cycles(8);
		async_nreset = 1'b1;
		wait_cycles(2);

		u_checker.begin_test("after reset");
		u_checker.check_value("txd", 32'h1, {31'h0, txd});
		checked_read(ADDR_STATUS, 32'h0);
		u_checker.finish_test();

		for (int step = 0; step < MAX_STEPS && steps[step][23:16] != 8'h00; step++)
		begin
			{kind, arg_a, arg_b} = steps[step];
			case (kind)
				8'h01: receive_byte(arg_a, arg_b[0]);
				8'h02: transmit_byte(arg_a, int'(arg_b));
				8'h03: receive_overrun(arg_a, arg_b);
				default:
					u_checker.report_problem($sformatf("Unknown step kind %0h in stimulus file.",
						kind));
			endcase
		end

		u_checker.report_counts();
		if (error_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		int frames;
		int step_count;
		int limit;
		#1; // Stimulus file is loaded at time zero.
		frames = 0;
		step_count = 1;
		for (int i = 0; i < MAX_STEPS && steps[i][23:16] != 8'h00; i++)
		begin
			step_count++;
			frames += (steps[i][23:16] == 8'h03) ? 2 : 1;
		end
		limit = frames * 12 * BIT_CYCLES + step_count * 200 + 2000;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests finished.", limit);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/uart_stim.txt */
// Columns: kind (2 hex digits), byte (2 hex digits), argument (2 hex digits).
// Kind 01 receive, argument 01 for good parity and 00 for bad parity.
// Kind 02 transmit, argument is the number of writes made while busy.
// Kind 03 overrun, the argument is the second byte.
015a01 // Receive 0x5a.
010001 // Receive 0x00.
01ff01 // Receive 0xff.
01a500 // Receive 0xa5 with bad parity.
013c00 // Receive 0x3c with bad parity.
025a00 // Transmit 0x5a.
020100 // Transmit 0x01.
028000 // Transmit 0x80.
02c302 // Transmit 0xc3 with two dropped writes.
027e03 // Transmit 0x7e with three dropped writes.
031122 // Overrun 0x11 then 0x22.
03ff00 // Overrun 0xff then 0x00.
019601 // Receive 0x96.
02f001 // Transmit 0xf0 with one dropped write.

/* filelist.f */
hw/uart_pkg.sv
hw/uart_timer.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_wb_regs.sv
hw/uart_top.sv
tests/uart_checker.sv
tests/tb_uart_top.sv

/* Bender.yml */
package:
  name: uart_wb

sources:
  - hw/uart_pkg.sv
  - hw/uart_timer.sv
  - hw/uart_rx.sv
  - hw/uart_tx.sv
  - hw/uart_wb_regs.sv
  - hw/uart_top.sv
  - target: test
    files:
      - tests/uart_checker.sv
      - tests/tb_uart_top.sv
